// ==== all.f ====
+incdir+design
design/sniff_pkg.sv
design/c0tx_req_checker.sv
design/c1tx_beat_checker.sv
design/mmio_rsp_tracker.sv
design/sniff_error_log.sv
design/ccip_sniffer.sv
test/ccip_sniffer_props.sv
test/sniff_monitor.sv
test/ccip_sniffer_tb.sv

// ==== design/c0tx_req_checker.sv ====
// Channel 0 read request header check
// Fields are looked at only while c0tx_valid is high
// One code per request, first failing rule wins
// Error strobe is registered, one cycle after the request
`include "sniff_settings.svh"

module c0tx_req_checker (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      c0tx_valid,
   input  sniff_pkg::c0_req_t        c0tx_req_type,
   input  sniff_pkg::cl_len_t        c0tx_cl_len,
   input  logic [`SNIFF_ADDR_W-1:0]  c0tx_addr,
   output logic                      c0_err,
   output sniff_pkg::sniff_code_t    c0_code
);
   import sniff_pkg::*;

   sniff_code_t chk_code;

   // Rule order: type, length, alignment
   always_comb begin
      chk_code = NO_ERROR;
      if ((c0tx_req_type != RDLINE_I) && (c0tx_req_type != RDLINE_S)) begin
         chk_code = C0TX_INVALID_REQTYPE;
      end else if (c0tx_cl_len == CL_LEN_3) begin
         chk_code = C0TX_ILLEGAL_CLLEN;
      end else if ((c0tx_cl_len == CL_LEN_2) && c0tx_addr[0]) begin
         // Two lines need an even start line
         chk_code = C0TX_ADDRALIGN_2;
      end else if ((c0tx_cl_len == CL_LEN_4) && (c0tx_addr[1:0] != 2'b00)) begin
         // Four lines need a 4-line boundary
         chk_code = C0TX_ADDRALIGN_4;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         c0_err  <= 1'b0;
         c0_code <= NO_ERROR;
      end else if (c0tx_valid) begin
         c0_err  <= (chk_code != NO_ERROR);
         c0_code <= chk_code;
      end else begin
         // Idle cycle, strobe drops
         c0_err  <= 1'b0;
         c0_code <= NO_ERROR;
      end
   end

endmodule

// ==== design/c1tx_beat_checker.sv ====
// Channel 1 write request and multi-line burst check
// Every valid strobe inside a burst counts as one beat, errors included
// A burst opens on any 2-line or 4-line write line outside a burst
// Fence is legal only between bursts
// Error strobe is registered, one cycle after the beat
`include "sniff_settings.svh"

module c1tx_beat_checker (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      c1tx_valid,
   input  sniff_pkg::c1_req_t        c1tx_req_type,
   input  logic                      c1tx_sop,
   input  sniff_pkg::cl_len_t        c1tx_cl_len,
   input  logic [`SNIFF_ADDR_W-1:0]  c1tx_addr,
   input  logic [1:0]                c1tx_vc_sel,
   input  logic [`SNIFF_MDATA_W-1:0] c1tx_mdata,
   output logic                      c1_err,
   output sniff_pkg::sniff_code_t    c1_code
);
   import sniff_pkg::*;

   localparam int ADDR_W = `SNIFF_ADDR_W;

   logic                      wr_line;
   logic                      wr_fence;
   logic                      multi_line;
   logic                      burst_start;
   logic [ADDR_W-1:0]         exp_addr;
   sniff_code_t               chk_code;

   // Burst tracking
   logic                      in_burst;
   logic [1:0]                beat_idx;
   logic [1:0]                beats_left;
   logic [ADDR_W-1:0]         base_addr;
   logic [1:0]                exp_vc;
   logic [`SNIFF_MDATA_W-1:0] exp_mdata;

   assign wr_line     = (c1tx_req_type == WRLINE_I) || (c1tx_req_type == WRLINE_M);
   assign wr_fence    = (c1tx_req_type == WRFENCE);
   assign multi_line  = (c1tx_cl_len == CL_LEN_2) || (c1tx_cl_len == CL_LEN_4);
   assign burst_start = c1tx_valid && !in_burst && wr_line && multi_line;
   // Line address the current beat should carry
   assign exp_addr    = base_addr + ADDR_W'(beat_idx);

   // Rule order: type, length, alignment, SOP, address, VC, MDATA
   always_comb begin
      chk_code = NO_ERROR;
      if (!(wr_line || (wr_fence && !in_burst))) begin
         chk_code = C1TX_INVALID_REQTYPE;
      end else if (wr_line && (c1tx_cl_len == CL_LEN_3)) begin
         chk_code = C1TX_ILLEGAL_CLLEN;
      end else if (!in_burst && wr_line && (c1tx_cl_len == CL_LEN_2) && c1tx_addr[0]) begin
         chk_code = C1TX_ADDRALIGN_2;
      end else if (!in_burst && wr_line && (c1tx_cl_len == CL_LEN_4) &&
                   (c1tx_addr[1:0] != 2'b00)) begin
         chk_code = C1TX_ADDRALIGN_4;
      end else if (!in_burst && wr_line && !c1tx_sop) begin
         // First or only line must mark SOP
         chk_code = C1TX_SOP_NOT_SET;
      end else if (in_burst && c1tx_sop) begin
         chk_code = C1TX_SOP_SET_MCL;
      end else if (in_burst && (c1tx_addr != exp_addr)) begin
         chk_code = C1TX_UNEXP_ADDR;
      end else if (in_burst && (c1tx_vc_sel != exp_vc)) begin
         chk_code = C1TX_UNEXP_VCSEL;
      end else if (in_burst && (c1tx_mdata != exp_mdata)) begin
         // Only a warning, first beat MDATA is the one used
         chk_code = C1TX_UNEXP_MDATA;
      end
   end

   // Burst state, exits after the counted last beat
   always_ff @(posedge clk) begin
      if (rst) begin
         in_burst   <= 1'b0;
         beat_idx   <= 2'd0;
         beats_left <= 2'd0;
      end else if (c1tx_valid) begin
         if (burst_start) begin
            in_burst   <= 1'b1;
            beat_idx   <= 2'd1;
            // Lines minus one, the beats still to come
            beats_left <= c1tx_cl_len;
         end else if (in_burst) begin
            beat_idx   <= beat_idx + 2'd1;
            beats_left <= beats_left - 2'd1;
            if (beats_left == 2'd1) begin
               in_burst <= 1'b0;
            end
         end
      end
   end

   // First beat header, reference for later beats
   always_ff @(posedge clk) begin
      if (burst_start) begin
         base_addr <= c1tx_addr;
         exp_vc    <= c1tx_vc_sel;
         exp_mdata <= c1tx_mdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         c1_err  <= 1'b0;
         c1_code <= NO_ERROR;
      end else if (c1tx_valid) begin
         c1_err  <= (chk_code != NO_ERROR);
         c1_code <= chk_code;
      end else begin
         c1_err  <= 1'b0;
         c1_code <= NO_ERROR;
      end
   end

endmodule

// ==== design/ccip_sniffer.sv ====
// Protocol checker for the accelerator port, observe only
// Header fields sampled only while their valid strobe is high
// err_valid rises two cycles after the offending input cycle
`include "sniff_settings.svh"

module ccip_sniffer (
   input  logic                      clk,
   input  logic                      rst,
   // Channel 0 read requests
   input  logic                      c0tx_valid,
   input  sniff_pkg::c0_req_t        c0tx_req_type,
   input  sniff_pkg::cl_len_t        c0tx_cl_len,
   input  logic [`SNIFF_ADDR_W-1:0]  c0tx_addr,
   // Channel 1 write requests
   input  logic                      c1tx_valid,
   input  sniff_pkg::c1_req_t        c1tx_req_type,
   input  logic                      c1tx_sop,
   input  sniff_pkg::cl_len_t        c1tx_cl_len,
   input  logic [`SNIFF_ADDR_W-1:0]  c1tx_addr,
   input  logic [1:0]                c1tx_vc_sel,
   input  logic [`SNIFF_MDATA_W-1:0] c1tx_mdata,
   // MMIO read request and response
   input  logic                      mmio_rd_valid,
   input  logic [`SNIFF_TID_W-1:0]   mmio_rd_tid,
   input  logic                      mmio_rsp_valid,
   input  logic [`SNIFF_TID_W-1:0]   mmio_rsp_tid,
   // Error report
   output logic                      err_valid,
   output sniff_pkg::sniff_code_t    err_code,
   output logic                      err_warn,
   output logic [`SNIFF_CNT_W-1:0]   err_count,
   output sniff_pkg::sniff_code_t    first_err_code
);

   logic                   c0_err;
   sniff_pkg::sniff_code_t c0_code;
   logic                   c1_err;
   sniff_pkg::sniff_code_t c1_code;
   logic                   mmio_err;
   sniff_pkg::sniff_code_t mmio_code;

   c0tx_req_checker c0tx_req_checker_inst (
      .clk, .rst, .c0tx_valid, .c0tx_req_type, .c0tx_cl_len, .c0tx_addr,
      .c0_err, .c0_code
   );

   c1tx_beat_checker c1tx_beat_checker_inst (
      .clk, .rst, .c1tx_valid, .c1tx_req_type, .c1tx_sop, .c1tx_cl_len,
      .c1tx_addr, .c1tx_vc_sel, .c1tx_mdata, .c1_err, .c1_code
   );

   mmio_rsp_tracker mmio_rsp_tracker_inst (
      .clk, .rst, .mmio_rd_valid, .mmio_rd_tid, .mmio_rsp_valid, .mmio_rsp_tid,
      .mmio_err, .mmio_code
   );

   sniff_error_log sniff_error_log_inst (
      .clk, .rst, .c0_err, .c0_code, .c1_err, .c1_code, .mmio_err, .mmio_code,
      .err_valid, .err_code, .err_warn, .err_count, .first_err_code
   );

endmodule

// ==== design/mmio_rsp_tracker.sv ====
// MMIO read request/response tracking, one entry per TID
// Timeout strobe rises SNIFF_MMIO_TIMEOUT cycles after the request cycle
// Unsolicited response wins over a timeout, which then waits a cycle
// Simultaneous timeouts are reported one per cycle, lowest TID first
`include "sniff_settings.svh"

module mmio_rsp_tracker (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     mmio_rd_valid,
   input  logic [`SNIFF_TID_W-1:0]  mmio_rd_tid,
   input  logic                     mmio_rsp_valid,
   input  logic [`SNIFF_TID_W-1:0]  mmio_rsp_tid,
   output logic                     mmio_err,
   output sniff_pkg::sniff_code_t   mmio_code
);
   import sniff_pkg::*;

   localparam int TID_W   = `SNIFF_TID_W;
   localparam int DEPTH   = 1 << TID_W;
   localparam int TIMER_W = `SNIFF_TIMER_W;
   // Timer is 0 after the request edge; hitting this value at an edge
   // registers the strobe exactly SNIFF_MMIO_TIMEOUT cycles after the request
   localparam logic [TIMER_W-1:0] TIMER_LIMIT = TIMER_W'(`SNIFF_MMIO_TIMEOUT - 2);

   logic [DEPTH-1:0]   active;
   logic [TIMER_W-1:0] timer [DEPTH];
   logic [DEPTH-1:0]   expired;
   logic [TID_W-1:0]   sel_tid;
   logic               unsolicited;
   logic               report_to;

   // Expired entries not answered in this same cycle
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         expired[i] = active[i] && (timer[i] == TIMER_LIMIT) &&
                      !(mmio_rsp_valid && (mmio_rsp_tid == TID_W'(i)));
      end
   end

   // Lowest expired TID, downward scan so the last hit wins
   always_comb begin
      sel_tid = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (expired[i]) begin
            sel_tid = TID_W'(i);
         end
      end
   end

   assign unsolicited = mmio_rsp_valid && !active[mmio_rsp_tid];
   assign report_to   = (|expired) && !unsolicited;

   always_ff @(posedge clk) begin
      if (rst) begin
         active    <= '0;
         mmio_err  <= 1'b0;
         mmio_code <= NO_ERROR;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            // New request replaces whatever the entry held
            if (mmio_rd_valid && (mmio_rd_tid == TID_W'(i))) begin
               active[i] <= 1'b1;
            end else if (mmio_rsp_valid && (mmio_rsp_tid == TID_W'(i))) begin
               active[i] <= 1'b0;
            end else if (report_to && (sel_tid == TID_W'(i))) begin
               active[i] <= 1'b0;
            end
         end
         mmio_err  <= unsolicited || report_to;
         mmio_code <= unsolicited ? MMIO_RDRSP_UNSOLICITED :
                      report_to   ? MMIO_RDRSP_TIMEOUT : NO_ERROR;
      end
   end

   // Timers run while active and park at the limit until reported
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (mmio_rd_valid && (mmio_rd_tid == TID_W'(i))) begin
            timer[i] <= '0;
         end else if (active[i] && (timer[i] != TIMER_LIMIT)) begin
            timer[i] <= timer[i] + 1'b1;
         end
      end
   end

endmodule

// ==== design/sniff_error_log.sv ====
// Merges the checker strobes into one registered error report
// Priority: MMIO tracker, then channel 1, then channel 0
// err_count adds every strobe, including those not reported
// err_count wraps at 2**SNIFF_CNT_W
`include "sniff_settings.svh"

module sniff_error_log (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    c0_err,
   input  sniff_pkg::sniff_code_t  c0_code,
   input  logic                    c1_err,
   input  sniff_pkg::sniff_code_t  c1_code,
   input  logic                    mmio_err,
   input  sniff_pkg::sniff_code_t  mmio_code,
   output logic                    err_valid,
   output sniff_pkg::sniff_code_t  err_code,
   output logic                    err_warn,
   output logic [`SNIFF_CNT_W-1:0] err_count,
   output sniff_pkg::sniff_code_t  first_err_code
);
   import sniff_pkg::*;

   localparam int CNT_W = `SNIFF_CNT_W;

   logic        sel_valid;
   sniff_code_t sel_code;
   logic [1:0]  num_strobes;

   assign sel_valid   = mmio_err || c1_err || c0_err;
   assign sel_code    = mmio_err ? mmio_code :
                        c1_err   ? c1_code   :
                        c0_err   ? c0_code   : NO_ERROR;
   assign num_strobes = {1'b0, mmio_err} + {1'b0, c1_err} + {1'b0, c0_err};

   always_ff @(posedge clk) begin
      if (rst) begin
         err_valid      <= 1'b0;
         err_code       <= NO_ERROR;
         err_warn       <= 1'b0;
         err_count      <= '0;
         first_err_code <= NO_ERROR;
      end else begin
         err_valid <= sel_valid;
         err_code  <= sel_code;
         err_warn  <= sel_valid && sniff_is_warning(sel_code);
         err_count <= err_count + CNT_W'(num_strobes);
         // Reported codes are never NO_ERROR, so it marks "none yet"
         if (sel_valid && (first_err_code == NO_ERROR)) begin
            first_err_code <= sel_code;
         end
      end
   end

endmodule

// ==== design/sniff_pkg.sv ====
// Request encodings and error codes of the port checker
// Error code values follow declaration order, NO_ERROR is 0
// Only the MDATA change inside a write burst counts as a warning
`include "sniff_settings.svh"

package sniff_pkg;

   // Channel 0 read requests, any other value is illegal
   typedef enum logic [`SNIFF_REQ_W-1:0] {
      RDLINE_I = 4'h0,
      RDLINE_S = 4'h1
   } c0_req_t;

   // Channel 1 write requests, any other value is illegal
   typedef enum logic [`SNIFF_REQ_W-1:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRFENCE  = 4'h4
   } c1_req_t;

   // Line count minus one
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'd0,
      CL_LEN_2 = 2'd1,
      CL_LEN_3 = 2'd2,
      CL_LEN_4 = 2'd3
   } cl_len_t;

   typedef enum logic [4:0] {
      NO_ERROR,
      C0TX_INVALID_REQTYPE,
      C0TX_ILLEGAL_CLLEN,
      C0TX_ADDRALIGN_2,
      C0TX_ADDRALIGN_4,
      C1TX_INVALID_REQTYPE,
      C1TX_ILLEGAL_CLLEN,
      C1TX_ADDRALIGN_2,
      C1TX_ADDRALIGN_4,
      C1TX_SOP_NOT_SET,
      C1TX_SOP_SET_MCL,
      C1TX_UNEXP_ADDR,
      C1TX_UNEXP_VCSEL,
      C1TX_UNEXP_MDATA,
      MMIO_RDRSP_TIMEOUT,
      MMIO_RDRSP_UNSOLICITED
   } sniff_code_t;

   // Warnings are logged and counted like errors but flagged apart
   function automatic logic sniff_is_warning(input sniff_code_t code);
      return code == C1TX_UNEXP_MDATA;
   endfunction

endpackage

// ==== design/sniff_settings.svh ====
// Shared widths and limits for the port checker
// Address is a cache-line address, so bit 0 is line granularity
// The MMIO tracker holds one entry per TID, 2**SNIFF_TID_W in total
// SNIFF_TIMER_W must hold SNIFF_MMIO_TIMEOUT
`ifndef SNIFF_SETTINGS_SVH
`define SNIFF_SETTINGS_SVH

// Request header fields
`define SNIFF_ADDR_W 32
`define SNIFF_MDATA_W 16
`define SNIFF_REQ_W 4

// MMIO read tracking
`define SNIFF_TID_W 4
`define SNIFF_MMIO_TIMEOUT 64
`define SNIFF_TIMER_W 7

// Error log
`define SNIFF_CNT_W 16

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the port checker testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
   --top-module ccip_sniffer_tb -o ccip_sniffer_sim
./obj_dir/ccip_sniffer_sim +verilator+error+limit+100 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
echo "Run passed"

// ==== test/ccip_sniffer_props.sv ====
// Concurrent checks on the error report of the port checker
// Bound into ccip_sniffer; fail_count sums all assertion failures
// err_count is assumed not to wrap during a run
`include "sniff_settings.svh"

module ccip_sniffer_props (
   input logic                    clk,
   input logic                    rst,
   input logic                    err_valid,
   input sniff_pkg::sniff_code_t  err_code,
   input logic                    err_warn,
   input logic [`SNIFF_CNT_W-1:0] err_count,
   input sniff_pkg::sniff_code_t  first_err_code
);
   import sniff_pkg::*;

   int code_fails = 0;
   int warn_fails = 0;
   int count_fails = 0;
   int first_fails = 0;
   int fail_count;

   assign fail_count = code_fails + warn_fails + count_fails + first_fails;

   valid_has_code: assert property (@(posedge clk) disable iff (rst)
      err_valid |-> (err_code != NO_ERROR))
   else begin
      $error("err_valid high with no error code");
      code_fails++;
   end

   // A warning is always a logged report
   warn_needs_valid: assert property (@(posedge clk) disable iff (rst)
      err_warn |-> err_valid)
   else begin
      $error("err_warn high while err_valid low");
      warn_fails++;
   end

   count_monotonic: assert property (@(posedge clk) disable iff (rst)
      err_count >= $past(err_count))
   else begin
      $error("err_count decreased without reset");
      count_fails++;
   end

   first_code_holds: assert property (@(posedge clk) disable iff (rst)
      ($past(first_err_code) != NO_ERROR) |-> (first_err_code == $past(first_err_code)))
   else begin
      $error("first_err_code changed after being set");
      first_fails++;
   end

endmodule

// ==== test/ccip_sniffer_tb.sv ====
// Testbench for the port checker, run from the project root
// Stimulus and expected codes come from test/sniff_stimulus.hex
// One 136-bit word per cycle, driven on the falling edge
// Words not present in the file are idle cycles with no expected error
// sniff_monitor does all comparing; this module decides the final verdict
`include "sniff_settings.svh"

module ccip_sniffer_tb;
   import sniff_pkg::*;

   localparam int NUM_WORDS    = 100;
   localparam int WORD_W       = 136;
   localparam int DONE_TIMEOUT = 16;

   logic                      clk;
   logic                      rst;
   logic                      c0tx_valid;
   c0_req_t                   c0tx_req_type;
   cl_len_t                   c0tx_cl_len;
   logic [`SNIFF_ADDR_W-1:0]  c0tx_addr;
   logic                      c1tx_valid;
   c1_req_t                   c1tx_req_type;
   logic                      c1tx_sop;
   cl_len_t                   c1tx_cl_len;
   logic [`SNIFF_ADDR_W-1:0]  c1tx_addr;
   logic [1:0]                c1tx_vc_sel;
   logic [`SNIFF_MDATA_W-1:0] c1tx_mdata;
   logic                      mmio_rd_valid;
   logic [`SNIFF_TID_W-1:0]   mmio_rd_tid;
   logic                      mmio_rsp_valid;
   logic [`SNIFF_TID_W-1:0]   mmio_rsp_tid;
   logic                      err_valid;
   sniff_code_t               err_code;
   logic                      err_warn;
   logic [`SNIFF_CNT_W-1:0]   err_count;
   sniff_code_t               first_err_code;

   // Scoreboard side
   logic                      word_valid;
   logic [3:0]                exp_group;
   logic [4:0]                exp_code;
   logic                      mon_done;
   int                        mon_errors;

   logic [WORD_W-1:0]         stim_mem [NUM_WORDS];

   ccip_sniffer ccip_sniffer_inst (
      .clk, .rst,
      .c0tx_valid, .c0tx_req_type, .c0tx_cl_len, .c0tx_addr,
      .c1tx_valid, .c1tx_req_type, .c1tx_sop, .c1tx_cl_len, .c1tx_addr,
      .c1tx_vc_sel, .c1tx_mdata,
      .mmio_rd_valid, .mmio_rd_tid, .mmio_rsp_valid, .mmio_rsp_tid,
      .err_valid, .err_code, .err_warn, .err_count, .first_err_code
   );

   bind ccip_sniffer ccip_sniffer_props ccip_sniffer_props_inst (
      .clk(clk), .rst(rst), .err_valid(err_valid), .err_code(err_code),
      .err_warn(err_warn), .err_count(err_count), .first_err_code(first_err_code)
   );

   sniff_monitor sniff_monitor_inst (
      .clk, .rst, .word_valid, .exp_group, .exp_code,
      .err_valid, .err_code, .err_warn, .err_count, .first_err_code,
      .prop_failures(ccip_sniffer_inst.ccip_sniffer_props_inst.fail_count),
      .done(mon_done), .total_errors(mon_errors)
   );

   // All inputs idle, no word on the port
   task automatic clear_inputs();
      word_valid     = 1'b0;
      exp_group      = 4'd0;
      exp_code       = 5'd0;
      c0tx_valid     = 1'b0;
      c0tx_req_type  = RDLINE_I;
      c0tx_cl_len    = CL_LEN_1;
      c0tx_addr      = '0;
      c1tx_valid     = 1'b0;
      c1tx_req_type  = WRLINE_I;
      c1tx_sop       = 1'b0;
      c1tx_cl_len    = CL_LEN_1;
      c1tx_addr      = '0;
      c1tx_vc_sel    = 2'd0;
      c1tx_mdata     = '0;
      mmio_rd_valid  = 1'b0;
      mmio_rd_tid    = '0;
      mmio_rsp_valid = 1'b0;
      mmio_rsp_tid   = '0;
   endtask

   // Field layout follows the column comment in the stimulus file
   task automatic apply_word(input logic [WORD_W-1:0] word);
      word_valid     = 1'b1;
      exp_group      = word[135:132];
      exp_code       = {1'b0, word[131:128]};
      c0tx_valid     = word[124];
      c0tx_req_type  = c0_req_t'(word[123:120]);
      c0tx_cl_len    = cl_len_t'(word[117:116]);
      c0tx_addr      = word[115:84];
      c1tx_valid     = word[80];
      c1tx_req_type  = c1_req_t'(word[79:76]);
      c1tx_sop       = word[72];
      c1tx_cl_len    = cl_len_t'(word[69:68]);
      c1tx_vc_sel    = word[65:64];
      c1tx_addr      = word[63:32];
      c1tx_mdata     = word[31:16];
      mmio_rd_valid  = word[12];
      mmio_rd_tid    = word[11:8];
      mmio_rsp_valid = word[4];
      mmio_rsp_tid   = word[3:0];
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      int wait_cycles;
      rst = 1'b1;
      clear_inputs();
      // Gaps in the file stay idle
      for (int i = 0; i < NUM_WORDS; i++) begin
         stim_mem[i] = '0;
      end
      $readmemh("test/sniff_stimulus.hex", stim_mem);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < NUM_WORDS; i++) begin
         apply_word(stim_mem[i]);
         @(negedge clk);
      end
      clear_inputs();
      // Pipeline drains in a few cycles
      wait_cycles = 0;
      while (!mon_done && (wait_cycles < DONE_TIMEOUT)) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (mon_done && (mon_errors == 0)) begin
         $display("SIMULATION PASSED");
      end else begin
         if (!mon_done) begin
            $display("Timeout: monitor gave no summary within %0d cycles", DONE_TIMEOUT);
         end
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== test/sniff_monitor.sv ====
// Scoreboard for the port checker
// Expected code of a word is checked against err_valid, err_code and err_warn
// on the falling edge after the second rising edge that follows the word
// Words arrive in one unbroken run, the first empty slot ends the check
// Final err_count and first_err_code are derived from the expected codes
`include "sniff_settings.svh"

module sniff_monitor (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    word_valid,
   input  logic [3:0]              exp_group,
   input  logic [4:0]              exp_code,
   input  logic                    err_valid,
   input  sniff_pkg::sniff_code_t  err_code,
   input  logic                    err_warn,
   input  logic [`SNIFF_CNT_W-1:0] err_count,
   input  sniff_pkg::sniff_code_t  first_err_code,
   input  int                      prop_failures,
   output logic                    done,
   output int                      total_errors
);
   import sniff_pkg::*;

   // Delay line matching checker stage plus log stage
   logic       valid_d1;
   logic       valid_d2;
   logic [3:0] group_d1;
   logic [3:0] group_d2;
   logic [4:0] code_d1;
   logic [4:0] code_d2;

   int         words_checked = 0;
   int         mismatches = 0;
   int         exp_count = 0;
   logic [4:0] exp_first = 5'd0;
   logic       finished = 1'b0;
   int         error_sum = 0;

   assign done         = finished;
   assign total_errors = error_sum;

   function automatic string group_name(input logic [3:0] group);
      case (group)
         4'd1:    return "legal_traffic";
         4'd2:    return "header_rules";
         4'd3:    return "write_burst";
         4'd4:    return "mmio_tracking";
         default: return "idle";
      endcase
   endfunction

   // Only the MDATA change inside a burst is a warning
   function automatic logic expect_warning(input logic [4:0] code);
      return code == 5'(C1TX_UNEXP_MDATA);
   endfunction

   task automatic check_value(input string test, input int word, input string field,
                              input int expected, input int actual);
      if (expected != actual) begin
         $display("FAILED %s word %0d %s: expected %0d, actual %0d",
                  test, word, field, expected, actual);
         mismatches++;
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         valid_d1 <= 1'b0;
         valid_d2 <= 1'b0;
      end else begin
         valid_d1 <= word_valid;
         valid_d2 <= valid_d1;
      end
      group_d1 <= exp_group;
      group_d2 <= group_d1;
      code_d1  <= exp_code;
      code_d2  <= code_d1;
   end

   // Outputs settle after the rising edge, compare mid-cycle
   always @(negedge clk) begin
      if (valid_d2) begin
         check_value(group_name(group_d2), words_checked, "err_valid",
                     int'(code_d2 != 5'd0), int'(err_valid));
         check_value(group_name(group_d2), words_checked, "err_code",
                     int'(code_d2), int'(err_code));
         check_value(group_name(group_d2), words_checked, "err_warn",
                     int'(expect_warning(code_d2)), int'(err_warn));
         if (code_d2 != 5'd0) begin
            exp_count++;
            if (exp_first == 5'd0) begin
               exp_first = code_d2;
            end
         end
         words_checked++;
      end else if ((words_checked > 0) && !finished) begin
         check_value("final_totals", words_checked, "err_count", exp_count, int'(err_count));
         check_value("final_totals", words_checked, "first_err_code",
                     int'(exp_first), int'(first_err_code));
         error_sum = mismatches + prop_failures;
         $display("Summary: %0d words checked, %0d mismatches, %0d property failures",
                  words_checked, mismatches, prop_failures);
         finished = 1'b1;
      end
   end

endmodule

// ==== test/sniff_stimulus.hex ====
// Columns: group+code | c0 valid,type,len addr | c1 valid,type,sop,len,vc addr mdata
//          | mmio rd valid,rd tid,rsp valid,rsp tid; code is expected two edges later
10_100_00000010_00000_00000000_0000_0000
10_111_00000020_00000_00000000_0000_0000
10_103_00000040_00000_00000000_0000_0000
10_000_00000000_10100_00000100_0011_0000
10_000_00000000_14000_00000000_0000_0000
10_000_00000000_11111_00000200_00a0_0000
10_000_00000000_11011_00000201_00a0_0000
10_000_00000000_00000_00000000_0000_1300
10_000_00000000_00000_00000000_0000_0000
10_000_00000000_00000_00000000_0000_0013
21_170_00000000_00000_00000000_0000_0000
22_102_00000000_00000_00000000_0000_0000
23_101_00000001_00000_00000000_0000_0000
24_103_00000002_00000_00000000_0000_0000
25_000_00000000_12100_00000000_0000_0000
26_000_00000000_10120_00000300_0000_0000
27_000_00000000_10110_00000301_0000_0000
20_000_00000000_10010_00000302_0000_0000
28_000_00000000_10130_00000402_0000_0000
25_000_00000000_14000_00000000_0000_0000
20_000_00000000_10030_00000404_0000_0000
20_000_00000000_10030_00000405_0000_0000
39_000_00000000_10032_00000500_00b0_0000
3a_000_00000000_10132_00000501_00b0_0000
3b_000_00000000_10032_00000503_00b0_0000
3c_000_00000000_10031_00000503_00b0_0000
30_000_00000000_10130_00000600_00c0_0000
3d_000_00000000_10030_00000601_00c1_0000
30_000_00000000_10030_00000602_00c0_0000
30_000_00000000_10030_00000603_00c0_0000
4f_000_00000000_00000_00000000_0000_0015
40_000_00000000_00000_00000000_0000_1900
40_000_00000000_00000_00000000_0000_1200
40_000_00000000_00000_00000000_0000_0000
40_000_00000000_00000_00000000_0000_0012
// TID 9 requested in word 31 times out, expected in word 94
@5e
4e_000_00000000_00000_00000000_0000_0000
40_000_00000000_00000_00000000_0000_0000
4f_000_00000000_00000_00000000_0000_0019
